// File: hdl/prci_pkg.sv
// --------------------
// Shared PRCI definitions: bus widths,
// APB FSM states, register map, cause bits
// --------------------
`default_nettype none

package prci_pkg;

    // Bus widths
    localparam int unsigned PRCI_ADDR_W = 12;
    localparam int unsigned PRCI_DATA_W = 32;
    localparam int unsigned REG_IDX_W   = PRCI_ADDR_W - 2;   // Word index, byte bits dropped

    // Decoder FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,     // Waiting for setup phase
        ST_REQ  = 2'd1,     // Request strobe high
        ST_WAIT = 2'd2,     // Waiting for result stage
        ST_RESP = 2'd3      // pready high
    } apb_state_e;

    // Register word index, paddr[11:2]
    typedef enum logic [REG_IDX_W-1:0] {
        REG_PLL_STATUS  = 10'd0,    // RO: sys_locked, ddr_locked
        REG_RST_STATUS  = 10'd1,    // sys_nrst, dbg_nrst; bit 0 write starts sw reset
        REG_RST_CAUSE   = 10'd2,    // Sticky, write 1 to clear
        REG_RST_STRETCH = 10'd3     // Stretch length
    } prci_reg_e;

    // Reset cause bit positions
    localparam int unsigned CAUSE_POR = 0;
    localparam int unsigned CAUSE_PLL = 1;
    localparam int unsigned CAUSE_DBG = 2;
    localparam int unsigned CAUSE_SW  = 3;
    localparam int unsigned CAUSE_W   = 4;

endpackage : prci_pkg

`default_nettype wire

// File: hdl/prci_req_if.sv
// --------------------
// Register request bundle, decoder to
// execute and result stages
// --------------------
`timescale 1ns/1ps
`default_nettype none

interface prci_req_if;
    import prci_pkg::*;

    logic                   req_valid;  // One-cycle strobe
    logic [PRCI_ADDR_W-1:0] req_addr;   // Byte address
    logic                   req_write;  // 1 = write
    logic [PRCI_DATA_W-1:0] req_wdata;

    // Driven by the APB decoder
    modport master (
        output req_valid,
        output req_addr,
        output req_write,
        output req_wdata
    );

    // Read by reset control and result stage
    modport target (
        input req_valid,
        input req_addr,
        input req_write,
        input req_wdata
    );

endinterface : prci_req_if

`default_nettype wire

// File: hdl/apb_req_decode.sv
// --------------------
// APB slave FSM: turns transfers into
// one-cycle register requests
// --------------------
`timescale 1ns/1ps
`default_nettype none

module apb_req_decode (
    input  logic                             i_clk,
    input  logic                             i_pwrreset,   // Async, active high
    // APB slave side
    input  logic                             i_psel,
    input  logic                             i_penable,
    input  logic                             i_pwrite,
    input  logic [prci_pkg::PRCI_ADDR_W-1:0] i_paddr,
    input  logic [prci_pkg::PRCI_DATA_W-1:0] i_pwdata,
    output logic                             o_pready,
    output logic [prci_pkg::PRCI_DATA_W-1:0] o_prdata,
    output logic                             o_pslverr,
    // Internal request
    prci_req_if.master                       req_bus,
    // Response from result stage
    input  logic                             i_resp_valid,
    input  logic [prci_pkg::PRCI_DATA_W-1:0] i_resp_rdata,
    input  logic                             i_resp_err
);
    import prci_pkg::*;

    apb_state_e             state_q;
    apb_state_e             state_nxt;
    logic                   setup_phase;
    logic [PRCI_ADDR_W-1:0] addr_q;
    logic [PRCI_DATA_W-1:0] wdata_q;
    logic                   write_q;

    assign setup_phase = i_psel && !i_penable;  // First APB cycle

    // Next state
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE: if (setup_phase) state_nxt = ST_REQ;
            ST_REQ:  state_nxt = ST_WAIT;               // Strobe lasts one cycle
            ST_WAIT: if (i_resp_valid) state_nxt = ST_RESP;
            ST_RESP: state_nxt = ST_IDLE;               // pready for one cycle only
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    // Capture transfer at setup; master holds it until pready anyway
    always_ff @(posedge i_clk) begin
        if (state_q == ST_IDLE && setup_phase) begin
            addr_q  <= i_paddr;
            wdata_q <= i_pwdata;
            write_q <= i_pwrite;
        end
    end

    // Registered response, zero outside the pready cycle
    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            o_pready  <= 1'b0;
            o_prdata  <= '0;
            o_pslverr <= 1'b0;
        end else if (state_q == ST_WAIT && i_resp_valid) begin
            o_pready  <= 1'b1;
            o_prdata  <= i_resp_rdata;
            o_pslverr <= i_resp_err;
        end else begin
            o_pready  <= 1'b0;
            o_prdata  <= '0;
            o_pslverr <= 1'b0;
        end
    end

    // Request strobe straight from state
    assign req_bus.req_valid = (state_q == ST_REQ);
    assign req_bus.req_addr  = addr_q;
    assign req_bus.req_write = write_q;
    assign req_bus.req_wdata = wdata_q;

endmodule : apb_req_decode

`default_nettype wire

// File: hdl/prci_reset_ctrl.sv
// --------------------
// Reset controller: synchronizers, stretch
// counter, sw reset, cause/stretch regs
// --------------------
`timescale 1ns/1ps
`default_nettype none

module prci_reset_ctrl #(
    parameter int unsigned STRETCH_W           = 8,
    parameter int unsigned RST_STRETCH_DEFAULT = 4
) (
    input  logic                         i_clk,
    input  logic                         i_pwrreset,    // Power-on reset, async
    input  logic                         i_dmireset,    // Debug reset request
    input  logic                         i_sys_locked,  // System PLL lock
    prci_req_if.target                   req_bus,
    output logic                         o_sys_rst,     // Active high
    output logic                         o_sys_nrst,    // Active low
    output logic                         o_dbg_nrst,    // Debug domain reset, active low
    output logic [prci_pkg::CAUSE_W-1:0] o_cause,
    output logic [STRETCH_W-1:0]         o_stretch
);
    import prci_pkg::*;

    // Synchronizer lanes
    localparam int unsigned SYNC_DMI  = 0;
    localparam int unsigned SYNC_LOCK = 1;
    localparam int unsigned SYNC_POR  = 2;

    logic [2:0]           sync_meta;
    logic [2:0]           sync_q;
    logic                 por_act;
    logic                 pll_lost;
    logic                 dmi_act;
    logic                 any_src;
    prci_reg_e            req_idx;
    logic                 wr_req;
    logic                 sw_req;           // One-cycle sw reset pulse
    logic [STRETCH_W-1:0] cnt_q;
    logic [CAUSE_W-1:0]   cause_set;
    logic [CAUSE_W-1:0]   cause_clr;

    // Two-flop synchronizers; POR lane shifts out zeros after release,
    // lock lane starts as locked so no false PLL cause at power-up
    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            sync_meta <= 3'b110;
            sync_q    <= 3'b110;
        end else begin
            sync_meta <= {1'b0, i_sys_locked, i_dmireset};
            sync_q    <= sync_meta;
        end
    end

    assign por_act  = sync_q[SYNC_POR];
    assign pll_lost = ~sync_q[SYNC_LOCK];
    assign dmi_act  = sync_q[SYNC_DMI];
    assign any_src  = por_act | pll_lost | dmi_act | sw_req;

    assign req_idx = prci_reg_e'(req_bus.req_addr[PRCI_ADDR_W-1:2]);   // Byte bits ignored
    assign wr_req  = req_bus.req_valid && req_bus.req_write;

    // Write 1 to RST_STATUS[0] starts a software reset
    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            sw_req <= 1'b0;
        end else begin
            sw_req <= wr_req && (req_idx == REG_RST_STATUS) && req_bus.req_wdata[0];
        end
    end

    // Stretch counter: reloaded while any source active, then counts out
    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            cnt_q     <= '0;
            o_sys_rst <= 1'b1;
        end else if (any_src) begin
            cnt_q     <= o_stretch;
            o_sys_rst <= 1'b1;
        end else if (cnt_q != '0) begin
            cnt_q     <= cnt_q - 1'b1;
            o_sys_rst <= 1'b1;             // Holds stretch + 1 cycles in total
        end else begin
            o_sys_rst <= 1'b0;
        end
    end

    assign o_sys_nrst = ~o_sys_rst;

    // Debug domain only sees POR and PLL loss, no stretch
    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            o_dbg_nrst <= 1'b0;
        end else begin
            o_dbg_nrst <= ~(por_act | pll_lost);
        end
    end

    // Cause bits
    always_comb begin
        cause_set            = '0;
        cause_set[CAUSE_POR] = por_act;
        cause_set[CAUSE_PLL] = pll_lost;
        cause_set[CAUSE_DBG] = dmi_act;
        cause_set[CAUSE_SW]  = sw_req;
    end

    assign cause_clr = (wr_req && req_idx == REG_RST_CAUSE) ?
                       req_bus.req_wdata[CAUSE_W-1:0] : '0;

    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            o_cause            <= '0;
            o_cause[CAUSE_POR] <= 1'b1;
        end else begin
            o_cause <= (o_cause & ~cause_clr) | cause_set;     // New cause beats clear
        end
    end

    // Stretch length register
    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            o_stretch <= STRETCH_W'(RST_STRETCH_DEFAULT);
        end else if (wr_req && req_idx == REG_RST_STRETCH) begin
            o_stretch <= req_bus.req_wdata[STRETCH_W-1:0];
        end
    end

endmodule : prci_reset_ctrl

`default_nettype wire

// File: hdl/prci_reg_result.sv
// --------------------
// Result stage: read mux, unmapped error,
// registered response
// --------------------
`timescale 1ns/1ps
`default_nettype none

module prci_reg_result #(
    parameter int unsigned STRETCH_W = 8
) (
    input  logic                             i_clk,
    input  logic                             i_pwrreset,
    prci_req_if.target                       req_bus,
    input  logic                             i_sys_locked,  // Raw PLL levels
    input  logic                             i_ddr_locked,
    input  logic                             i_sys_nrst,
    input  logic                             i_dbg_nrst,
    input  logic [prci_pkg::CAUSE_W-1:0]     i_cause,
    input  logic [STRETCH_W-1:0]             i_stretch,
    output logic                             o_resp_valid,
    output logic [prci_pkg::PRCI_DATA_W-1:0] o_resp_rdata,
    output logic                             o_resp_err
);
    import prci_pkg::*;

    prci_reg_e              req_idx;
    logic [PRCI_DATA_W-1:0] rdata_c;
    logic                   err_c;

    assign req_idx = prci_reg_e'(req_bus.req_addr[PRCI_ADDR_W-1:2]);

    // Read mux, unused bits zero
    always_comb begin
        rdata_c = '0;
        err_c   = 1'b0;
        case (req_idx)
            REG_PLL_STATUS: begin
                rdata_c[0] = i_sys_locked;
                rdata_c[1] = i_ddr_locked;
            end
            REG_RST_STATUS: begin
                rdata_c[0] = i_sys_nrst;
                rdata_c[1] = i_dbg_nrst;
            end
            REG_RST_CAUSE:   rdata_c[CAUSE_W-1:0]   = i_cause;
            REG_RST_STRETCH: rdata_c[STRETCH_W-1:0] = i_stretch;
            default:         err_c = 1'b1;  // Unmapped, reads and writes alike
        endcase
    end

    always_ff @(posedge i_clk or posedge i_pwrreset) begin
        if (i_pwrreset) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= req_bus.req_valid;  // Exactly one cycle behind
        end
    end

    // Payload only loads on a request
    always_ff @(posedge i_clk) begin
        if (req_bus.req_valid) begin
            o_resp_rdata <= req_bus.req_write ? '0 : rdata_c;
            o_resp_err   <= err_c;
        end
    end

endmodule : prci_reg_result

`default_nettype wire

// File: hdl/prci_top.sv
// --------------------
// PRCI top: APB decoder, reset control
// and result stage
// --------------------
`timescale 1ns/1ps
`default_nettype none

module prci_top #(
    parameter int unsigned STRETCH_W           = 8,
    parameter int unsigned RST_STRETCH_DEFAULT = 4
) (
    input  logic                             i_clk,
    input  logic                             i_pwrreset,
    input  logic                             i_dmireset,
    input  logic                             i_sys_locked,
    input  logic                             i_ddr_locked,
    // APB
    input  logic                             i_psel,
    input  logic                             i_penable,
    input  logic                             i_pwrite,
    input  logic [prci_pkg::PRCI_ADDR_W-1:0] i_paddr,
    input  logic [prci_pkg::PRCI_DATA_W-1:0] i_pwdata,
    output logic                             o_pready,
    output logic [prci_pkg::PRCI_DATA_W-1:0] o_prdata,
    output logic                             o_pslverr,
    // Resets
    output logic                             o_sys_rst,
    output logic                             o_sys_nrst,
    output logic                             o_dbg_nrst
);
    import prci_pkg::*;

    prci_req_if req_bus ();

    logic                   resp_valid;
    logic [PRCI_DATA_W-1:0] resp_rdata;
    logic                   resp_err;
    logic [CAUSE_W-1:0]     cause;
    logic [STRETCH_W-1:0]   stretch;

    apb_req_decode u_decode (
        .i_clk        (i_clk),
        .i_pwrreset   (i_pwrreset),     // APB path ignores sw reset
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_pready     (o_pready),
        .o_prdata     (o_prdata),
        .o_pslverr    (o_pslverr),
        .req_bus      (req_bus.master),
        .i_resp_valid (resp_valid),
        .i_resp_rdata (resp_rdata),
        .i_resp_err   (resp_err)
    );

    prci_reset_ctrl #(
        .STRETCH_W           (STRETCH_W),
        .RST_STRETCH_DEFAULT (RST_STRETCH_DEFAULT)
    ) u_reset_ctrl (
        .i_clk        (i_clk),
        .i_pwrreset   (i_pwrreset),
        .i_dmireset   (i_dmireset),
        .i_sys_locked (i_sys_locked),
        .req_bus      (req_bus.target),
        .o_sys_rst    (o_sys_rst),
        .o_sys_nrst   (o_sys_nrst),
        .o_dbg_nrst   (o_dbg_nrst),
        .o_cause      (cause),
        .o_stretch    (stretch)
    );

    prci_reg_result #(
        .STRETCH_W (STRETCH_W)
    ) u_result (
        .i_clk        (i_clk),
        .i_pwrreset   (i_pwrreset),
        .req_bus      (req_bus.target),
        .i_sys_locked (i_sys_locked),
        .i_ddr_locked (i_ddr_locked),
        .i_sys_nrst   (o_sys_nrst),     // Status read back from reset outputs
        .i_dbg_nrst   (o_dbg_nrst),
        .i_cause      (cause),
        .i_stretch    (stretch),
        .o_resp_valid (resp_valid),
        .o_resp_rdata (resp_rdata),
        .o_resp_err   (resp_err)
    );

endmodule : prci_top

`default_nettype wire

// File: tests/prci_assertions.sv
// --------------------
// Bound checks for APB pready and pslverr
// rules and reset output polarity
// --------------------
`timescale 1ns/1ps
`default_nettype none

module prci_assertions #(
    parameter bit CHECK_RST = 1'b1      // Instance sees the reset outputs
) (
    input logic i_clk,
    input logic i_pwrreset,
    input logic i_pready,
    input logic i_pslverr,
    input logic i_sys_rst,
    input logic i_sys_nrst
);

    int fail_cnt = 0;                   // Number of failed assertions

    // pready is a single-cycle pulse
    assert property (@(posedge i_clk) disable iff (i_pwrreset)
        i_pready |=> !i_pready)
        else begin
            fail_cnt++;
            $error("pready high for two cycles in a row");
        end

    // Error only in the pready cycle
    assert property (@(posedge i_clk) disable iff (i_pwrreset)
        i_pslverr |-> i_pready)
        else begin
            fail_cnt++;
            $error("pslverr high without pready");
        end

    if (CHECK_RST) begin : g_rst_chk
        assert property (@(posedge i_clk) disable iff (i_pwrreset)
            i_sys_nrst == !i_sys_rst)      // Both polarities agree
            else begin
                fail_cnt++;
                $error("o_sys_nrst is not the inverse of o_sys_rst");
            end
    end

endmodule : prci_assertions

// Decoder side carries only the APB handshake
bind apb_req_decode prci_assertions #(
    .CHECK_RST (1'b0)
) u_apb_chk (
    .i_clk      (i_clk),
    .i_pwrreset (i_pwrreset),
    .i_pready   (o_pready),
    .i_pslverr  (o_pslverr),
    .i_sys_rst  (),
    .i_sys_nrst ()
);

bind prci_top prci_assertions u_top_chk (
    .i_clk      (i_clk),
    .i_pwrreset (i_pwrreset),
    .i_pready   (o_pready),
    .i_pslverr  (o_pslverr),
    .i_sys_rst  (o_sys_rst),
    .i_sys_nrst (o_sys_nrst)
);

`default_nettype wire

// File: tests/tb_prci.sv
// --------------------
// PRCI testbench with clock, reset, APB table,
// LFSR stretch values and reset source tests
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_prci;
    import prci_pkg::*;

    localparam int unsigned STRETCH_W   = 8;
    localparam int unsigned STRETCH_DEF = 4;
    localparam int unsigned TBL_LEN     = 13;
    localparam int unsigned APB_TMO     = 50;   // Cycles to wait for pready
    localparam int unsigned RUN_TMO     = 600;  // Cycles to wait for a reset run
    localparam int unsigned N_RAND      = 8;

    typedef struct {
        logic                   wr;
        logic [PRCI_ADDR_W-1:0] addr;
        logic [PRCI_DATA_W-1:0] wdata;
        logic [PRCI_DATA_W-1:0] exp_rdata;
        logic                   exp_err;
    } xfer_t;

    logic                   i_clk = 1'b0;
    logic                   i_pwrreset;
    logic                   i_dmireset;
    logic                   i_sys_locked;
    logic                   i_ddr_locked;
    logic                   i_psel;
    logic                   i_penable;
    logic                   i_pwrite;
    logic [PRCI_ADDR_W-1:0] i_paddr;
    logic [PRCI_DATA_W-1:0] i_pwdata;
    logic                   o_pready;
    logic                   o_pslverr;
    logic [PRCI_DATA_W-1:0] o_prdata;
    logic                   o_sys_rst;
    logic                   o_sys_nrst;
    logic                   o_dbg_nrst;

    xfer_t       tbl [TBL_LEN];
    int          tbl_cnt = 0;
    int          data_errs = 0;
    int          flag_errs = 0;
    int          other_errs = 0;
    int          assert_errs = 0;
    logic [15:0] lfsr = 16'd86;
    int          run_len = 0;       // Length of current o_sys_rst high run in cycles
    int          last_run = 0;
    logic        run_done = 1'b0;
    logic        dbg_low_seen = 1'b0;

    always #5 i_clk = ~i_clk;       // 10 ns period

    prci_top #(
        .STRETCH_W           (STRETCH_W),
        .RST_STRETCH_DEFAULT (STRETCH_DEF)
    ) i_dut (
        .i_clk        (i_clk),
        .i_pwrreset   (i_pwrreset),
        .i_dmireset   (i_dmireset),
        .i_sys_locked (i_sys_locked),
        .i_ddr_locked (i_ddr_locked),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_pready     (o_pready),
        .o_prdata     (o_prdata),
        .o_pslverr    (o_pslverr),
        .o_sys_rst    (o_sys_rst),
        .o_sys_nrst   (o_sys_nrst),
        .o_dbg_nrst   (o_dbg_nrst)
    );

    // Reset run monitor sampled mid-cycle
    always @(negedge i_clk) begin
        if (o_sys_rst) begin
            run_len = run_len + 1;
            if (!o_dbg_nrst) dbg_low_seen = 1'b1;
        end else if (run_len != 0) begin
            last_run = run_len;
            run_len  = 0;
            run_done = 1'b1;
        end
    end

    // Watchdog scaled to the table length
    initial begin
        #((TBL_LEN * 20 + 2000) * 10);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) s = s ^ 16'hB400;  // Galois taps 16,14,13,11
        return s;
    endfunction

    function automatic logic [PRCI_DATA_W-1:0] rand_word();
        logic [PRCI_DATA_W-1:0] v;
        v = '0;
        for (int b = 0; b < PRCI_DATA_W; b++) begin
            lfsr = lfsr_next(lfsr);         // One step per bit
            v    = {v[PRCI_DATA_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_data(input string name, input logic [PRCI_DATA_W-1:0] exp,
                              input logic [PRCI_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR t=%0t %s exp=%b act=%b", $time, name, exp, act);
            flag_errs++;
        end
    endtask

    task automatic add_entry(input logic wr, input logic [PRCI_ADDR_W-1:0] addr,
                             input logic [PRCI_DATA_W-1:0] wdata,
                             input logic [PRCI_DATA_W-1:0] exp_rdata, input logic exp_err);
        tbl[tbl_cnt] = '{wr, addr, wdata, exp_rdata, exp_err};
        tbl_cnt++;
    endtask

    // One APB transfer through setup and access up to pready
    task automatic apb_check(input logic wr, input logic [PRCI_ADDR_W-1:0] addr,
                             input logic [PRCI_DATA_W-1:0] wdata,
                             input logic [PRCI_DATA_W-1:0] exp_rdata, input logic exp_err);
        int n;
        n = 0;
        @(posedge i_clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge i_clk);
        i_penable <= 1'b1;
        @(negedge i_clk);
        while (!o_pready && n < APB_TMO) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_pready) begin
            $display("APB transfer to address %h never got pready", addr);
            other_errs++;
        end
        check_data("o_prdata", exp_rdata, o_prdata);
        check_flag("o_pslverr", exp_err, o_pslverr);
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic wait_run_done();
        int n;
        n = 0;
        while (!run_done && n < RUN_TMO) begin
            @(negedge i_clk);
            n++;
        end
        if (!run_done) begin
            $display("System reset did not release in time");
            other_errs++;
        end
    endtask

    task automatic start_run();
        run_done     = 1'b0;
        dbg_low_seen = 1'b0;
    endtask

    initial begin
        logic [PRCI_DATA_W-1:0] val;
        int                     n;
        i_pwrreset = 1'b1;
        i_dmireset = 1'b0;
        i_sys_locked = 1'b1;
        i_ddr_locked = 1'b0;
        i_psel = 1'b0;
        i_penable = 1'b0;
        i_pwrite = 1'b0;
        i_paddr = '0;
        i_pwdata = '0;

        // Power-on values and unmapped accesses
        add_entry(0, 12'h008, 0, 32'h1, 0);                 // Cause holds POR only
        add_entry(0, 12'h00C, 0, STRETCH_DEF, 0);
        add_entry(0, 12'h004, 0, 32'h3, 0);                 // No reset active
        add_entry(1, 12'h010, 32'hFFFF_FFFF, 0, 1);         // Index 4
        add_entry(0, 12'h010, 0, 0, 1);
        add_entry(1, 12'hFFC, 32'h1234_5679, 0, 1);         // Index 0x3FF
        add_entry(0, 12'hFFC, 0, 0, 1);
        add_entry(0, 12'h00C, 0, STRETCH_DEF, 0);           // Unchanged by bad writes
        add_entry(0, 12'h008, 0, 32'h1, 0);
        add_entry(0, 12'h004, 0, 32'h3, 0);
        add_entry(1, 12'h008, 32'hF, 0, 0);                 // Clear all causes
        add_entry(0, 12'h008, 0, 0, 0);
        add_entry(0, 12'h00E, 0, STRETCH_DEF, 0);           // Byte bits ignored

        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        check_flag("o_sys_rst", 1'b1, o_sys_rst);
        check_flag("o_sys_nrst", 1'b0, o_sys_nrst);
        check_flag("o_dbg_nrst", 1'b0, o_dbg_nrst);
        check_flag("o_pready", 1'b0, o_pready);
        check_flag("o_pslverr", 1'b0, o_pslverr);
        check_data("o_prdata", '0, o_prdata);
        @(posedge i_clk);
        i_pwrreset <= 1'b0;

        // Release bound is two sync stages plus stretch plus 1
        n = 0;
        @(negedge i_clk);
        while (o_sys_rst && n < RUN_TMO) begin
            n++;
            @(negedge i_clk);
        end
        if (n > 2 + STRETCH_DEF + 1) begin
            $display("o_sys_rst stayed high %0d cycles after power-on reset, limit %0d",
                     n, 2 + STRETCH_DEF + 1);
            other_errs++;
        end
        check_flag("o_dbg_nrst", 1'b1, o_dbg_nrst);

        for (int i = 0; i < tbl_cnt; i++) begin
            apb_check(tbl[i].wr, tbl[i].addr, tbl[i].wdata, tbl[i].exp_rdata, tbl[i].exp_err);
        end

        // PLL status for every lock combination
        start_run();
        for (int c = 3; c >= 0; c--) begin
            @(posedge i_clk);
            i_sys_locked <= c[1];
            i_ddr_locked <= c[0];
            repeat (3) @(posedge i_clk);
            apb_check(0, 12'h000, 0, {30'd0, c[0], c[1]}, 0);
        end
        @(posedge i_clk);
        i_sys_locked <= 1'b1;
        wait_run_done();
        apb_check(1, 12'h008, 32'hF, 0, 0);
        apb_check(0, 12'h004, 0, 32'h3, 0);

        // Random stretch values read back masked
        for (int i = 0; i < N_RAND; i++) begin
            val = rand_word();
            apb_check(1, 12'h00C, val, 0, 0);
            apb_check(0, 12'h00C, 0, val & ((32'd1 << STRETCH_W) - 1), 0);
        end

        // Software reset with a known stretch
        apb_check(1, 12'h00C, 32'd5, 0, 0);
        start_run();
        apb_check(1, 12'h004, 32'h1, 0, 0);
        wait_run_done();
        check_data("sw_reset_cycles", 32'd6, last_run);
        check_flag("o_dbg_nrst_low_in_sw_reset", 1'b0, dbg_low_seen);
        apb_check(0, 12'h008, 0, 32'h1 << CAUSE_SW, 0);
        apb_check(1, 12'h008, 32'h1 << CAUSE_SW, 0, 0);
        apb_check(0, 12'h008, 0, 0, 0);

        // Debug reset pulse
        start_run();
        @(posedge i_clk);
        i_dmireset <= 1'b1;
        repeat (2) @(posedge i_clk);
        i_dmireset <= 1'b0;
        wait_run_done();
        check_flag("o_dbg_nrst_low_in_dbg_reset", 1'b0, dbg_low_seen);
        apb_check(0, 12'h008, 0, 32'h1 << CAUSE_DBG, 0);
        apb_check(1, 12'h008, 32'hF, 0, 0);

        // PLL lock loss
        start_run();
        @(posedge i_clk);
        i_sys_locked <= 1'b0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        check_flag("o_sys_rst", 1'b1, o_sys_rst);
        check_flag("o_dbg_nrst", 1'b0, o_dbg_nrst);
        @(posedge i_clk);
        i_sys_locked <= 1'b1;
        wait_run_done();
        apb_check(0, 12'h008, 0, 32'h1 << CAUSE_PLL, 0);
        apb_check(0, 12'h004, 0, 32'h3, 0);

        assert_errs = i_dut.u_decode.u_apb_chk.fail_cnt + i_dut.u_top_chk.fail_cnt;
        $display("Errors: data %0d, flag %0d, other %0d, assertion %0d",
                 data_errs, flag_errs, other_errs, assert_errs);
        if (data_errs + flag_errs + other_errs + assert_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_prci

`default_nettype wire

// File: verilog.f
hdl/prci_pkg.sv
hdl/prci_req_if.sv
hdl/apb_req_decode.sv
hdl/prci_reset_ctrl.sv
hdl/prci_reg_result.sv
hdl/prci_top.sv
tests/prci_assertions.sv
tests/tb_prci.sv

// File: Makefile
# Verilator build and run for the PRCI block

VERILATOR ?= verilator
TOP       ?= tb_prci
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINT_TOP  ?= prci_top

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Test failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Wall hdl/prci_pkg.sv hdl/prci_req_if.sv \
		hdl/apb_req_decode.sv hdl/prci_reset_ctrl.sv hdl/prci_reg_result.sv \
		hdl/prci_top.sv --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
